/* hdl/adc_pkg.sv */
package adc_pkg;

  // --------------------
  // converter geometry
  // --------------------

  // bits per sample, msb first on the lanes
  localparam int unsigned RESOLUTION = 18;

  // cycles from the cnv pulse to the first gated bit
  localparam int unsigned CONV_CYCLES = 4;

  // cnv cycle + conversion wait + one-lane gate + fall detect + valid
  localparam logic [31:0] MIN_PERIOD = 32'(1 + CONV_CYCLES + RESOLUTION + 2);

  // fixed sample shown instead of lane data in test-pattern mode
  localparam logic [RESOLUTION-1:0] TEST_PATTERN = 18'h3a5a5;

  // --------------------
  // register map
  // --------------------

  // identification word, read only
  localparam logic [31:0] CORE_VERSION = 32'h0001_0100;

  // byte offsets in the 16-bit space
  localparam logic [15:0] REG_VERSION = 16'h0000;
  localparam logic [15:0] REG_CONTROL = 16'h0004;
  localparam logic [15:0] REG_PERIOD  = 16'h0008;
  localparam logic [15:0] REG_COUNT   = 16'h000c;
  localparam logic [15:0] REG_STATUS  = 16'h0010;

  // control register fields
  localparam int unsigned CTRL_ENABLE   = 0;
  localparam int unsigned CTRL_TWOLANES = 1;
  localparam int unsigned CTRL_TESTPAT  = 2;

endpackage

/* hdl/adc_regmap.sv */
`timescale 1ns/1ps

module adc_regmap (
  input  logic        s_axi_aclk,
  input  logic        rst_n,
  // write address and data channels
  input  logic        s_axi_awvalid,
  input  logic [15:0] s_axi_awaddr,
  input  logic [ 2:0] s_axi_awprot,
  output logic        s_axi_awready,
  input  logic        s_axi_wvalid,
  input  logic [31:0] s_axi_wdata,
  input  logic [ 3:0] s_axi_wstrb,
  output logic        s_axi_wready,
  // write response
  output logic        s_axi_bvalid,
  output logic [ 1:0] s_axi_bresp,
  input  logic        s_axi_bready,
  // read address and data
  input  logic        s_axi_arvalid,
  input  logic [15:0] s_axi_araddr,
  input  logic [ 2:0] s_axi_arprot,
  output logic        s_axi_arready,
  output logic        s_axi_rvalid,
  output logic [ 1:0] s_axi_rresp,
  output logic [31:0] s_axi_rdata,
  input  logic        s_axi_rready,
  // capture side
  input  logic        adc_valid,
  input  logic        adc_dovf,
  output logic        enable,
  output logic        twolanes,
  output logic        testpat,
  output logic [31:0] period
);

  import adc_pkg::*;

  logic [ 2:0] ctrl;
  logic [31:0] sample_cnt;
  logic        ovf;
  logic        wr_take;
  logic        rd_take;
  logic        wr_en;
  logic [15:0] wr_addr;
  logic [15:0] rd_addr;
  logic [31:0] period_merged;
  logic [31:0] rd_value;

  // every access completes with OKAY
  assign s_axi_bresp = 2'b00;
  assign s_axi_rresp = 2'b00;

  // --------------------
  // write channel
  // --------------------

  // both halves of the write present and no response outstanding
  assign wr_take = s_axi_awvalid & s_axi_wvalid & ~s_axi_awready & ~s_axi_bvalid;
  // the ready pulse marks the handshake cycle
  assign wr_en   = s_axi_awready;
  assign wr_addr = {s_axi_awaddr[15:2], 2'b00};

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      s_axi_awready <= 1'b0;
      s_axi_wready  <= 1'b0;
      s_axi_bvalid  <= 1'b0;
    end else begin
      s_axi_awready <= wr_take;
      s_axi_wready  <= wr_take;
      // response follows the handshake and waits for bready
      if (s_axi_awready) begin
        s_axi_bvalid <= 1'b1;
      end else if (s_axi_bready) begin
        s_axi_bvalid <= 1'b0;
      end
    end
  end

  // byte lanes of the period word, old value where strobe is low
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      period_merged[8*i +: 8] = s_axi_wstrb[i] ? s_axi_wdata[8*i +: 8] : period[8*i +: 8];
    end
  end

  // --------------------
  // registers
  // --------------------

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl   <= '0;
      period <= MIN_PERIOD;
      ovf    <= 1'b0;
    end else begin
      if (wr_en && (wr_addr == REG_CONTROL) && s_axi_wstrb[0]) begin
        ctrl <= s_axi_wdata[2:0];
      end
      // short periods would overlap two conversions
      if (wr_en && (wr_addr == REG_PERIOD)) begin
        period <= (period_merged < MIN_PERIOD) ? MIN_PERIOD : period_merged;
      end
      // a new overflow beats a clear in the same cycle
      if (adc_dovf) begin
        ovf <= 1'b1;
      end else if (wr_en && (wr_addr == REG_STATUS) && s_axi_wstrb[0] && s_axi_wdata[0]) begin
        ovf <= 1'b0;
      end
    end
  end

  assign enable   = ctrl[CTRL_ENABLE];
  assign twolanes = ctrl[CTRL_TWOLANES];
  assign testpat  = ctrl[CTRL_TESTPAT];

  // samples since enable, restarts from zero on every enable
  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      sample_cnt <= '0;
    end else if (!enable) begin
      sample_cnt <= '0;
    end else if (adc_valid) begin
      sample_cnt <= sample_cnt + 32'd1;
    end
  end

  // --------------------
  // read channel
  // --------------------

  assign rd_take = s_axi_arvalid & ~s_axi_arready & ~s_axi_rvalid;
  assign rd_addr = {s_axi_araddr[15:2], 2'b00};

  always_comb begin
    case (rd_addr)
      REG_VERSION: rd_value = CORE_VERSION;
      REG_CONTROL: rd_value = {29'd0, ctrl};
      REG_PERIOD:  rd_value = period;
      REG_COUNT:   rd_value = sample_cnt;
      REG_STATUS:  rd_value = {31'd0, ovf};
      // holes in the map read as zero
      default:     rd_value = 32'd0;
    endcase
  end

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      s_axi_arready <= 1'b0;
      s_axi_rvalid  <= 1'b0;
    end else begin
      s_axi_arready <= rd_take;
      if (s_axi_arready) begin
        s_axi_rvalid <= 1'b1;
      end else if (s_axi_rready) begin
        s_axi_rvalid <= 1'b0;
      end
    end
  end

  // data is sampled in the arready cycle and held with rvalid
  always_ff @(posedge s_axi_aclk) begin
    if (s_axi_arready) begin
      s_axi_rdata <= rd_value;
    end
  end

endmodule

/* hdl/adc_cnv_timer.sv */
`timescale 1ns/1ps

module adc_cnv_timer (
  input  logic        s_axi_aclk,
  input  logic        rst_n,
  input  logic        enable,
  input  logic        twolanes,
  input  logic [31:0] period,
  output logic        cnv,
  output logic        clk_gate
);

  import adc_pkg::*;

  logic [31:0]                     period_cnt;
  logic                            conv_wait;
  logic [$clog2(CONV_CYCLES)-1:0]  wait_cnt;
  logic [$clog2(RESOLUTION)-1:0]   bit_cnt;
  logic [$clog2(RESOLUTION)-1:0]   bit_load;

  // --------------------
  // conversion period
  // --------------------

  // counter parked at zero while disabled, so cnv fires the cycle after enable
  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      period_cnt <= '0;
      cnv        <= 1'b0;
    end else if (!enable) begin
      period_cnt <= '0;
      cnv        <= 1'b0;
    end else if (period_cnt == '0) begin
      // reload so the next pulse lands exactly period cycles later
      period_cnt <= period - 32'd1;
      cnv        <= 1'b1;
    end else begin
      period_cnt <= period_cnt - 32'd1;
      cnv        <= 1'b0;
    end
  end

  // --------------------
  // conversion wait and gate
  // --------------------

  // bit times per sample, two bits per cycle with both lanes
  assign bit_load = twolanes ? $bits(bit_load)'(RESOLUTION / 2 - 1)
                             : $bits(bit_load)'(RESOLUTION - 1);

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      conv_wait <= 1'b0;
      wait_cnt  <= '0;
      clk_gate  <= 1'b0;
      bit_cnt   <= '0;
    end else if (!enable) begin
      // disable aborts the sample and shuts the gate at once
      conv_wait <= 1'b0;
      wait_cnt  <= '0;
      clk_gate  <= 1'b0;
      bit_cnt   <= '0;
    end else if (cnv) begin
      conv_wait <= 1'b1;
      wait_cnt  <= $bits(wait_cnt)'(CONV_CYCLES - 1);
    end else if (conv_wait) begin
      if (wait_cnt == '0) begin
        // converter done, open the gate for the lane mode length
        conv_wait <= 1'b0;
        clk_gate  <= 1'b1;
        bit_cnt   <= bit_load;
      end else begin
        wait_cnt <= wait_cnt - 1'b1;
      end
    end else if (clk_gate) begin
      if (bit_cnt == '0) begin
        clk_gate <= 1'b0;
      end else begin
        bit_cnt <= bit_cnt - 1'b1;
      end
    end
  end

endmodule

/* hdl/adc_lane_deser.sv */
`timescale 1ns/1ps

module adc_lane_deser (
  input  logic                           s_axi_aclk,
  input  logic                           rst_n,
  input  logic                           clk_gate,
  input  logic                           twolanes,
  input  logic                           testpat,
  input  logic                           da,
  input  logic                           db,
  output logic                           adc_valid,
  output logic [adc_pkg::RESOLUTION-1:0] adc_data
);

  import adc_pkg::*;

  logic                  gate_d;
  logic                  gate_fall;
  logic [RESOLUTION-1:0] shift_reg;

  // --------------------
  // lane shifter
  // --------------------

  // one rising edge per gated bit time, msb arrives first
  always_ff @(posedge s_axi_aclk) begin
    if (clk_gate) begin
      if (twolanes) begin
        // da holds the even bit from the top, db the one after it
        shift_reg <= {shift_reg[RESOLUTION-3:0], da, db};
      end else begin
        shift_reg <= {shift_reg[RESOLUTION-2:0], da};
      end
    end
  end

  // --------------------
  // sample hand-off
  // --------------------

  // first cycle with the gate closed, all bits are in the shifter
  assign gate_fall = gate_d & ~clk_gate;

  always_ff @(posedge s_axi_aclk or negedge rst_n) begin
    if (!rst_n) begin
      gate_d    <= 1'b0;
      adc_valid <= 1'b0;
    end else begin
      gate_d    <= clk_gate;
      // single cycle strobe, the DMA side cannot stall
      adc_valid <= gate_fall;
    end
  end

  // sample held until the next gate closes
  always_ff @(posedge s_axi_aclk) begin
    if (gate_fall) begin
      // Test pattern replaces the lane data but keeps the same strobe timing
      adc_data <= testpat ? TEST_PATTERN : shift_reg;
    end
  end

endmodule

/* hdl/adc_if_top.sv */
`timescale 1ns/1ps

module adc_if_top (
  input  logic                           s_axi_aclk,
  input  logic                           rst_n,
  // AXI4-Lite control port
  input  logic                           s_axi_awvalid,
  input  logic [15:0]                    s_axi_awaddr,
  input  logic [ 2:0]                    s_axi_awprot,
  output logic                           s_axi_awready,
  input  logic                           s_axi_wvalid,
  input  logic [31:0]                    s_axi_wdata,
  input  logic [ 3:0]                    s_axi_wstrb,
  output logic                           s_axi_wready,
  output logic                           s_axi_bvalid,
  output logic [ 1:0]                    s_axi_bresp,
  input  logic                           s_axi_bready,
  input  logic                           s_axi_arvalid,
  input  logic [15:0]                    s_axi_araddr,
  input  logic [ 2:0]                    s_axi_arprot,
  output logic                           s_axi_arready,
  output logic                           s_axi_rvalid,
  output logic [ 1:0]                    s_axi_rresp,
  output logic [31:0]                    s_axi_rdata,
  input  logic                           s_axi_rready,
  // converter pins
  input  logic                           da,
  input  logic                           db,
  output logic                           cnv,
  output logic                           clk_gate,
  // DMA side
  input  logic                           adc_dovf,
  output logic                           adc_valid,
  output logic [adc_pkg::RESOLUTION-1:0] adc_data
);

  // control fields from the register map
  logic        enable;
  logic        twolanes;
  logic        testpat;
  logic [31:0] period;

  // --------------------
  // register map
  // --------------------

  adc_regmap regmap_inst (
    .s_axi_aclk    (s_axi_aclk),
    .rst_n         (rst_n),
    .s_axi_awvalid (s_axi_awvalid),
    .s_axi_awaddr  (s_axi_awaddr),
    .s_axi_awprot  (s_axi_awprot),
    .s_axi_awready (s_axi_awready),
    .s_axi_wvalid  (s_axi_wvalid),
    .s_axi_wdata   (s_axi_wdata),
    .s_axi_wstrb   (s_axi_wstrb),
    .s_axi_wready  (s_axi_wready),
    .s_axi_bvalid  (s_axi_bvalid),
    .s_axi_bresp   (s_axi_bresp),
    .s_axi_bready  (s_axi_bready),
    .s_axi_arvalid (s_axi_arvalid),
    .s_axi_araddr  (s_axi_araddr),
    .s_axi_arprot  (s_axi_arprot),
    .s_axi_arready (s_axi_arready),
    .s_axi_rvalid  (s_axi_rvalid),
    .s_axi_rresp   (s_axi_rresp),
    .s_axi_rdata   (s_axi_rdata),
    .s_axi_rready  (s_axi_rready),
    .adc_valid     (adc_valid),
    .adc_dovf      (adc_dovf),
    .enable        (enable),
    .twolanes      (twolanes),
    .testpat       (testpat),
    .period        (period)
  );

  // --------------------
  // capture path
  // --------------------

  // cnv and clk_gate go to the pins and into the shifter
  adc_cnv_timer timer_inst (
    .s_axi_aclk (s_axi_aclk),
    .rst_n      (rst_n),
    .enable     (enable),
    .twolanes   (twolanes),
    .period     (period),
    .cnv        (cnv),
    .clk_gate   (clk_gate)
  );

  adc_lane_deser deser_inst (
    .s_axi_aclk (s_axi_aclk),
    .rst_n      (rst_n),
    .clk_gate   (clk_gate),
    .twolanes   (twolanes),
    .testpat    (testpat),
    .da         (da),
    .db         (db),
    .adc_valid  (adc_valid),
    .adc_data   (adc_data)
  );

endmodule

/* test/adc_if_checker.sv */
`timescale 1ns/1ps

module adc_if_checker (
  input logic        s_axi_aclk,
  input logic        rst_n,
  input logic        enable,
  input logic        twolanes,
  input logic        cnv,
  input logic        clk_gate,
  input logic        adc_valid,
  input logic        s_axi_bvalid,
  input logic        s_axi_bready,
  input logic        s_axi_rvalid,
  input logic        s_axi_rready,
  input logic [31:0] s_axi_rdata
);

  // failures seen so far, read by the bench at the end of the run
  int unsigned fail_count = 0;

  // --------------------
  // converter timing
  // --------------------

  cnv_single: assert property (@(posedge s_axi_aclk) disable iff (!rst_n)
    cnv |=> !cnv)
    else begin $error("cnv held high for more than one cycle"); fail_count++; end

  // gate window is 9 bit times with both lanes, 18 with one
  gate_two_lanes: assert property (@(posedge s_axi_aclk) disable iff (!rst_n || !enable)
    ($rose(clk_gate) && twolanes) |-> ##9 $fell(clk_gate))
    else begin $error("clk_gate window is not 9 cycles in two-lane mode"); fail_count++; end

  gate_one_lane: assert property (@(posedge s_axi_aclk) disable iff (!rst_n || !enable)
    ($rose(clk_gate) && !twolanes) |-> ##18 $fell(clk_gate))
    else begin $error("clk_gate window is not 18 cycles in one-lane mode"); fail_count++; end

  // strobe comes exactly one cycle after the gate closes, and only then
  valid_after_gate: assert property (@(posedge s_axi_aclk) disable iff (!rst_n)
    $fell(clk_gate) |=> adc_valid)
    else begin $error("adc_valid missing after the gate closed"); fail_count++; end

  valid_only_after_gate: assert property (@(posedge s_axi_aclk) disable iff (!rst_n)
    adc_valid |-> ($past(clk_gate, 2) && !$past(clk_gate)))
    else begin $error("adc_valid without a preceding gate fall"); fail_count++; end

  // --------------------
  // AXI response hold
  // --------------------

  bvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!rst_n)
    (s_axi_bvalid && !s_axi_bready) |=> s_axi_bvalid)
    else begin $error("bvalid dropped before bready"); fail_count++; end

  // read data also stays put while the master stalls
  rvalid_hold: assert property (@(posedge s_axi_aclk) disable iff (!rst_n)
    (s_axi_rvalid && !s_axi_rready) |=> (s_axi_rvalid && $stable(s_axi_rdata)))
    else begin $error("rvalid or rdata changed before rready"); fail_count++; end

endmodule

bind adc_if_top adc_if_checker checker_inst (
  .s_axi_aclk   (s_axi_aclk),
  .rst_n        (rst_n),
  .enable       (enable),
  .twolanes     (twolanes),
  .cnv          (cnv),
  .clk_gate     (clk_gate),
  .adc_valid    (adc_valid),
  .s_axi_bvalid (s_axi_bvalid),
  .s_axi_bready (s_axi_bready),
  .s_axi_rvalid (s_axi_rvalid),
  .s_axi_rready (s_axi_rready),
  .s_axi_rdata  (s_axi_rdata)
);

/* test/adc_if_tb.sv */
`timescale 1ns/1ps

module adc_if_tb;

  import adc_pkg::*;

  // about 40 conversions of up to 40 cycles, plus register traffic
  localparam int unsigned TIMEOUT_CYCLES = 5000;

  logic                  s_axi_aclk;
  logic                  rst_n;
  logic                  s_axi_awvalid;
  logic [15:0]           s_axi_awaddr;
  logic [ 2:0]           s_axi_awprot;
  logic                  s_axi_awready;
  logic                  s_axi_wvalid;
  logic [31:0]           s_axi_wdata;
  logic [ 3:0]           s_axi_wstrb;
  logic                  s_axi_wready;
  logic                  s_axi_bvalid;
  logic [ 1:0]           s_axi_bresp;
  logic                  s_axi_bready;
  logic                  s_axi_arvalid;
  logic [15:0]           s_axi_araddr;
  logic [ 2:0]           s_axi_arprot;
  logic                  s_axi_arready;
  logic                  s_axi_rvalid;
  logic [ 1:0]           s_axi_rresp;
  logic [31:0]           s_axi_rdata;
  logic                  s_axi_rready;
  logic                  da = 1'b0;
  logic                  db = 1'b0;
  logic                  cnv;
  logic                  clk_gate;
  logic                  adc_dovf;
  logic                  adc_valid;
  logic [RESOLUTION-1:0] adc_data;

  // converter model, scoreboard and bookkeeping
  logic [RESOLUTION-1:0] next_sample = 18'h3a5a5;
  logic [RESOLUTION-1:0] shift_word = '0;
  logic [RESOLUTION-1:0] exp_sample;
  logic                  load_two = 1'b0;
  logic                  two_mode;
  logic                  pat_mode;
  logic [RESOLUTION-1:0] expected_q[$];
  string                 test_name;
  int unsigned           cnv_count = 0;
  int unsigned           valid_count = 0;
  int unsigned           sample_checks = 0;
  int unsigned           sample_errors = 0;
  int unsigned           cycle_count = 0;
  int unsigned           checks;
  int unsigned           errors;
  int unsigned           cnv_mark;
  int unsigned           valid_mark;
  int unsigned           total_errors;
  logic [31:0]           rd_word;

  adc_if_top adc_if_inst (.*);

  initial s_axi_aclk = 1'b0;
  always #5 s_axi_aclk = ~s_axi_aclk;

  // --------------------
  // converter model and sample monitor
  // --------------------

  always @(negedge s_axi_aclk) begin
    if (rst_n) begin
      // a new conversion latches the next value of the counting sequence
      if (cnv) begin
        cnv_count++;
        shift_word = next_sample;
        load_two   = two_mode;
        expected_q.push_back(next_sample);
        next_sample = next_sample + 1'b1;
      end
      // msb first, db carries the bit below da with both lanes
      if (clk_gate) begin
        da = shift_word[RESOLUTION-1];
        if (load_two) begin
          db = shift_word[RESOLUTION-2];
          shift_word = shift_word << 2;
        end else begin
          shift_word = shift_word << 1;
        end
      end
      if (adc_valid) begin
        valid_count++;
        sample_checks++;
        if (expected_q.size() == 0) begin
          sample_errors++;
          $display("[ERROR] %s: sample arrived with no conversion started", test_name);
        end else begin
          exp_sample = expected_q.pop_front();
          if (pat_mode) begin
            exp_sample = TEST_PATTERN;
          end
          assert (adc_data === exp_sample) else begin
            sample_errors++;
            $display("[ERROR] %s: expected %h, actual %h", test_name, exp_sample, adc_data);
          end
        end
      end
    end
  end

  // --------------------
  // bus and check tasks
  // --------------------

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_at_least(input string name, input logic [31:0] minimum,
                                input logic [31:0] actual);
    checks++;
    assert (actual >= minimum) else begin
      errors++;
      $display("[ERROR] %s: expected at least %0d, actual %0d", name, minimum, actual);
    end
  endtask

  // master stall of 0 to 3 cycles before taking a response
  task automatic stall_master();
    repeat ($urandom_range(3, 0)) @(negedge s_axi_aclk);
  endtask

  task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    s_axi_awaddr  = addr;
    s_axi_wdata   = data;
    s_axi_wstrb   = strb;
    s_axi_awvalid = 1'b1;
    s_axi_wvalid  = 1'b1;
    do @(negedge s_axi_aclk); while (!s_axi_awready);
    // wready pulses in the same cycle as awready
    check_value($sformatf("%s wready", test_name), 32'd1, 32'(s_axi_wready));
    // address and data held through the handshake edge
    @(negedge s_axi_aclk);
    s_axi_awvalid = 1'b0;
    s_axi_wvalid  = 1'b0;
    while (!s_axi_bvalid) @(negedge s_axi_aclk);
    stall_master();
    check_value($sformatf("%s bresp", test_name), 32'd0, 32'(s_axi_bresp));
    s_axi_bready = 1'b1;
    @(negedge s_axi_aclk);
    s_axi_bready = 1'b0;
  endtask

  task automatic axi_read(input logic [15:0] addr, output logic [31:0] data);
    s_axi_araddr  = addr;
    s_axi_arvalid = 1'b1;
    do @(negedge s_axi_aclk); while (!s_axi_arready);
    @(negedge s_axi_aclk);
    s_axi_arvalid = 1'b0;
    while (!s_axi_rvalid) @(negedge s_axi_aclk);
    stall_master();
    check_value($sformatf("%s rresp", test_name), 32'd0, 32'(s_axi_rresp));
    data = s_axi_rdata;
    s_axi_rready = 1'b1;
    @(negedge s_axi_aclk);
    s_axi_rready = 1'b0;
  endtask

  task automatic read_check(input logic [15:0] addr, input logic [31:0] expected);
    logic [31:0] value;
    axi_read(addr, value);
    check_value($sformatf("%s reg %h", test_name, addr), expected, value);
  endtask

  // returns on the negedge that sees the n-th strobe
  task automatic wait_samples(input int unsigned n);
    repeat (n) begin
      do @(negedge s_axi_aclk); while (!adc_valid);
    end
  endtask

  // --------------------
  // timeout
  // --------------------

  always @(posedge s_axi_aclk) begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("checks: %0d, errors: %0d", checks + sample_checks,
               errors + sample_errors + adc_if_inst.checker_inst.fail_count);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // --------------------
  // tests
  // --------------------

  initial begin
    void'($urandom(63));
    rst_n         = 1'b0;
    s_axi_awvalid = 1'b0;
    s_axi_awaddr  = '0;
    s_axi_awprot  = '0;
    s_axi_wvalid  = 1'b0;
    s_axi_wdata   = '0;
    s_axi_wstrb   = '0;
    s_axi_bready  = 1'b0;
    s_axi_arvalid = 1'b0;
    s_axi_araddr  = '0;
    s_axi_arprot  = '0;
    s_axi_rready  = 1'b0;
    adc_dovf      = 1'b0;
    two_mode      = 1'b0;
    pat_mode      = 1'b0;
    checks        = 0;
    errors        = 0;
    test_name     = "reset";
    repeat (10) @(negedge s_axi_aclk);
    rst_n = 1'b1;
    @(negedge s_axi_aclk);

    test_name = "registers";
    read_check(REG_VERSION, CORE_VERSION);
    read_check(REG_PERIOD, MIN_PERIOD);
    read_check(REG_CONTROL, 32'd0);
    read_check(16'h0020, 32'd0);
    axi_write(REG_CONTROL, 32'h6, 4'hf);
    read_check(REG_CONTROL, 32'h6);
    axi_write(REG_CONTROL, 32'h0, 4'hf);
    axi_write(REG_PERIOD, 32'd40, 4'hf);
    read_check(REG_PERIOD, 32'd40);
    axi_write(REG_PERIOD, 32'd3, 4'hf);
    read_check(REG_PERIOD, MIN_PERIOD);
    // low byte lane only, upper bytes keep the clamped value
    axi_write(REG_PERIOD, 32'hffff_ff1e, 4'b0001);
    read_check(REG_PERIOD, 32'd30);

    test_name = "two_lane";
    two_mode  = 1'b1;
    axi_write(REG_CONTROL, 32'h3, 4'hf);
    wait_samples(10);
    axi_read(REG_COUNT, rd_word);
    check_at_least("two_lane count", 32'd10, rd_word);

    // mode changes land right after a strobe, well clear of the next gate
    test_name = "one_lane";
    wait_samples(1);
    two_mode = 1'b0;
    axi_write(REG_CONTROL, 32'h1, 4'hf);
    wait_samples(6);

    test_name = "test_pattern";
    axi_write(REG_CONTROL, 32'h5, 4'hf);
    // expected pattern follows once the control write is done
    pat_mode  = 1'b1;
    wait_samples(4);
    test_name = "pattern_off";
    axi_write(REG_CONTROL, 32'h1, 4'hf);
    pat_mode  = 1'b0;
    wait_samples(3);

    test_name = "overflow";
    read_check(REG_STATUS, 32'd0);
    adc_dovf = 1'b1;
    @(negedge s_axi_aclk);
    adc_dovf = 1'b0;
    read_check(REG_STATUS, 32'd1);
    repeat (20) @(negedge s_axi_aclk);
    read_check(REG_STATUS, 32'd1);
    axi_write(REG_STATUS, 32'd1, 4'hf);
    read_check(REG_STATUS, 32'd0);

    test_name = "disable";
    wait_samples(1);
    axi_write(REG_CONTROL, 32'h0, 4'hf);
    cnv_mark   = cnv_count;
    valid_mark = valid_count;
    repeat (80) @(negedge s_axi_aclk);
    check_value("disable cnv pulses", 32'd0, cnv_count - cnv_mark);
    check_value("disable valid strobes", 32'd0, valid_count - valid_mark);
    check_value("disable open conversions", 32'd0, 32'(expected_q.size()));
    read_check(REG_COUNT, 32'd0);

    // every read above and below stalls the master at random
    test_name = "back_pressure";
    repeat (6) begin
      read_check(REG_VERSION, CORE_VERSION);
      read_check(REG_PERIOD, 32'd30);
      read_check(REG_CONTROL, 32'd0);
    end

    total_errors = errors + sample_errors + adc_if_inst.checker_inst.fail_count;
    $display("checks: %0d, errors: %0d", checks + sample_checks, total_errors);
    if (total_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* all.f */
hdl/adc_pkg.sv
hdl/adc_regmap.sv
hdl/adc_cnv_timer.sv
hdl/adc_lane_deser.sv
hdl/adc_if_top.sv
test/adc_if_checker.sv
test/adc_if_tb.sv

/* Makefile */
# Verilator flow for the ADC capture block

TOP = adc_if_tb
RTL = hdl/adc_pkg.sv hdl/adc_regmap.sv hdl/adc_cnv_timer.sv hdl/adc_lane_deser.sv hdl/adc_if_top.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only $(RTL) --top-module adc_if_top
	verilator --lint-only --timing --assert -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o $(TOP)_sim
	./obj_dir/$(TOP)_sim +verilator+error+limit+1000 | tee sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
